// ==== source/ex_pkg.sv ====
package ex_pkg;

  // datapath width, one word
  localparam int unsigned xlen = 32;

  // one iterative step per operand bit
  localparam int unsigned iter_n = xlen;

  // operation codes, all sixteen in use
  // the top four belong to the iterative unit, low two bits give the mdu kind
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    SLL   = 4'd2,
    SLT   = 4'd3,
    SLTU  = 4'd4,
    XOR   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    OR    = 4'd8,
    AND   = 4'd9,
    SUBU  = 4'd10,
    PC    = 4'd11,
    MUL   = 4'd12,
    MULHU = 4'd13,
    DIVU  = 4'd14,
    REMU  = 4'd15
  } alu_op_e;

  // bit 0 picks the high word, bit 1 picks divide
  typedef enum logic [1:0] {
    MDU_MUL   = 2'd0,
    MDU_MULHU = 2'd1,
    MDU_DIVU  = 2'd2,
    MDU_REMU  = 2'd3
  } mdu_kind_e;

  typedef struct packed {
    alu_op_e           op;
    logic [xlen-1:0]   a;
    logic [xlen-1:0]   b;
    logic [xlen-1:0]   pc;
  } ex_req_t;

  typedef struct packed {
    logic [xlen-1:0]   result;
  } ex_rsp_t;

  // controller to datapath
  typedef struct packed {
    logic              load;
    logic              step;
    mdu_kind_e         kind;
  } mdu_cmd_t;

  // true for codes handled by the iterative unit
  function automatic logic is_mdu_op(input alu_op_e op);
    return op inside {MUL, MULHU, DIVU, REMU};
  endfunction

endpackage

// ==== source/ex_adder.sv ====
`timescale 1ns/1ps
module ex_adder (
  input  logic [ex_pkg::xlen-1:0] a,
  input  logic [ex_pkg::xlen-1:0] b,
  input  logic [ex_pkg::xlen-1:0] pc,
  input  ex_pkg::alu_op_e         op,
  output logic [ex_pkg::xlen-1:0] sum,
  output logic [ex_pkg::xlen-1:0] pc_link,
  output logic                    lt_signed,
  output logic                    lt_unsigned
);

  localparam int msb = ex_pkg::xlen - 1;

  logic                    is_sub;
  logic [ex_pkg::xlen-1:0] b_op;
  logic                    carry;
  logic                    overflow;

  // compares share the subtract path
  assign is_sub = op inside {ex_pkg::SUB, ex_pkg::SUBU, ex_pkg::SLT, ex_pkg::SLTU};

  // a - b as a + ~b + 1
  assign b_op = is_sub ? ~b : b;
  assign {carry, sum} = {1'b0, a} + {1'b0, b_op} + (ex_pkg::xlen + 1)'(is_sub);

  // signed overflow only when the operand signs differ
  assign overflow = (a[msb] ^ b[msb]) & (a[msb] ^ sum[msb]);

  // sign corrected by overflow
  assign lt_signed = sum[msb] ^ overflow;
  // no carry out means a borrow, so a < b
  assign lt_unsigned = ~carry;

  // link value for jumps
  assign pc_link = pc + ex_pkg::xlen'(4);

endmodule

// ==== source/ex_alu.sv ====
`timescale 1ns/1ps
module ex_alu (
  input  ex_pkg::alu_op_e         op,
  input  logic [ex_pkg::xlen-1:0] a,
  input  logic [ex_pkg::xlen-1:0] b,
  input  logic [ex_pkg::xlen-1:0] sum,
  input  logic [ex_pkg::xlen-1:0] pc_link,
  input  logic                    lt_signed,
  input  logic                    lt_unsigned,
  output logic [ex_pkg::xlen-1:0] result
);

  localparam int msb     = ex_pkg::xlen - 1;
  localparam int shamt_w = $clog2(ex_pkg::xlen);

  logic [ex_pkg::xlen-1:0] and_res;
  logic [ex_pkg::xlen-1:0] or_res;
  logic [ex_pkg::xlen-1:0] xor_res;
  logic                    is_sll;
  logic [ex_pkg::xlen-1:0] shift_src;
  logic [ex_pkg::xlen-1:0] shift_tmp;
  logic [ex_pkg::xlen-1:0] sra_mask;
  logic [ex_pkg::xlen-1:0] sll_res;
  logic [ex_pkg::xlen-1:0] sra_res;

  // mirror a word end for end
  function automatic logic [ex_pkg::xlen-1:0] reverse_bits(
    input logic [ex_pkg::xlen-1:0] v
  );
    logic [ex_pkg::xlen-1:0] r;
    for (int i = 0; i < ex_pkg::xlen; i++) begin
      r[msb-i] = v[i];
    end
    return r;
  endfunction

  // bitwise ops
  assign and_res = a & b;
  assign or_res  = a | b;
  assign xor_res = a ^ b;

  // one right shifter serves all three shifts
  // left shift is a right shift of the reversed word, reversed back
  assign is_sll    = (op == ex_pkg::SLL);
  assign shift_src = is_sll ? reverse_bits(a) : a;
  assign shift_tmp = shift_src >> b[shamt_w-1:0];
  assign sll_res   = reverse_bits(shift_tmp);

  // ones where shifted data lands, zeros where sign fill goes
  assign sra_mask = {ex_pkg::xlen{1'b1}} >> b[shamt_w-1:0];
  assign sra_res  = (shift_tmp & sra_mask) | ({ex_pkg::xlen{a[msb]}} & ~sra_mask);

  always_comb begin
    unique case (op)
      ex_pkg::ADD,
      ex_pkg::SUB,
      ex_pkg::SUBU:  result = sum;
      ex_pkg::SLL:   result = sll_res;
      ex_pkg::SLT:   result = {{(ex_pkg::xlen-1){1'b0}}, lt_signed};
      ex_pkg::SLTU:  result = {{(ex_pkg::xlen-1){1'b0}}, lt_unsigned};
      ex_pkg::XOR:   result = xor_res;
      ex_pkg::SRL:   result = shift_tmp;
      ex_pkg::SRA:   result = sra_res;
      ex_pkg::OR:    result = or_res;
      ex_pkg::AND:   result = and_res;
      ex_pkg::PC:    result = pc_link;
      // iterative unit supplies these
      ex_pkg::MUL,
      ex_pkg::MULHU,
      ex_pkg::DIVU,
      ex_pkg::REMU:  result = '0;
    endcase
  end

endmodule

// ==== source/ex_mdu_ctrl.sv ====
`timescale 1ns/1ps
module ex_mdu_ctrl (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              start,
  input  ex_pkg::mdu_kind_e kind,
  input  logic              last,
  output logic              cnt_load,
  output logic              cnt_en,
  output ex_pkg::mdu_cmd_t  cmd,
  output logic              busy,
  output logic              done
);

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    RUN,
    DONE
  } state_e;

  state_e            state;
  state_e            state_nxt;
  ex_pkg::mdu_kind_e kind_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // op kind kept for the whole operation
  always_ff @(posedge clk) begin
    if (start) begin
      kind_q <= kind;
    end
  end

  always_comb begin
    state_nxt = state;
    unique case (state)
      IDLE: if (start) state_nxt = LOAD;
      LOAD: state_nxt = RUN;
      // the step with last set is the final one
      RUN:  if (last) state_nxt = DONE;
      DONE: state_nxt = IDLE;
    endcase
  end

  // operands and counter load together
  assign cnt_load = (state == LOAD);
  // stop counting once zero is reached
  assign cnt_en   = (state == RUN) && !last;

  assign cmd.load = (state == LOAD);
  assign cmd.step = (state == RUN);
  assign cmd.kind = kind_q;

  assign busy = (state != IDLE);
  assign done = (state == DONE);

  // top must not start a second op while one is running
  a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy);

  // done lands exactly iter_n + 2 clocks after start, so it is a single pulse
  a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> $past(start, ex_pkg::iter_n + 2));

endmodule

// ==== source/ex_iter_counter.sv ====
`timescale 1ns/1ps
module ex_iter_counter #(
  parameter int unsigned steps = 32
) (
  input  logic clk,
  input  logic arst_n,
  input  logic load,
  input  logic en,
  output logic last
);

  localparam int cnt_w = (steps > 1) ? $clog2(steps) : 1;

  logic [cnt_w-1:0] count;

  // load steps-1, count down to zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (load) begin
      count <= cnt_w'(steps - 1);
    end else if (en) begin
      count <= count - 1'b1;
    end
  end

  assign last = (count == '0);

  // controller must stop enabling at zero, else the count wraps
  a_no_wrap: assert property (@(posedge clk) disable iff (!arst_n) !(en && last && !load));

endmodule

// ==== source/ex_mdu_datapath.sv ====
`timescale 1ns/1ps
module ex_mdu_datapath (
  input  logic                    clk,
  input  logic                    arst_n,
  input  ex_pkg::mdu_cmd_t        cmd,
  input  logic [ex_pkg::xlen-1:0] a,
  input  logic [ex_pkg::xlen-1:0] b,
  output logic [ex_pkg::xlen-1:0] result
);

  localparam int n = ex_pkg::xlen;

  // multiply, {partial high word, remaining multiplier bits}
  // divide,   {partial remainder, dividend bits then quotient bits}
  logic [2*n-1:0] acc;
  logic [2*n-1:0] acc_nxt;

  // multiply step
  logic [n:0]     mul_sum;

  // divide step
  logic [n:0]     rem_sh;
  logic [n+1:0]   diff;
  logic           borrow;

  // adding b into the high half and shifting right is the same as
  // adding the left-shifted multiplicand into a fixed accumulator
  assign mul_sum = {1'b0, acc[2*n-1:n]} + (acc[0] ? {1'b0, b} : '0);

  // remainder shifted left with the next dividend bit brought in
  assign rem_sh = acc[2*n-1:n-1];
  assign diff   = {1'b0, rem_sh} - {2'b00, b};
  assign borrow = diff[n+1];

  always_comb begin
    if (cmd.kind[1]) begin
      // restoring step, keep the difference only when it did not borrow
      // b == 0 never borrows, so quotient fills with ones and rem ends as a
      if (borrow) begin
        acc_nxt = {rem_sh[n-1:0], acc[n-2:0], 1'b0};
      end else begin
        acc_nxt = {diff[n-1:0], acc[n-2:0], 1'b1};
      end
    end else begin
      acc_nxt = {mul_sum, acc[n-1:1]};
    end
  end

  // both kinds start from {0, a}
  always_ff @(posedge clk) begin
    if (cmd.load) begin
      acc <= {{n{1'b0}}, a};
    end else if (cmd.step) begin
      acc <= acc_nxt;
    end
  end

  // MUL and DIVU take the low word, MULHU and REMU the high word
  assign result = cmd.kind[0] ? acc[2*n-1:n] : acc[n-1:0];

  // controller never loads and steps in the same cycle
  a_load_xor_step: assert property (@(posedge clk) disable iff (!arst_n)
    !(cmd.load && cmd.step));

endmodule

// ==== source/ex_stage.sv ====
`timescale 1ns/1ps
module ex_stage (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  ex_pkg::ex_req_t in_req,
  output logic            out_valid,
  input  logic            out_ready,
  output ex_pkg::ex_rsp_t out_rsp
);

  logic                    accept;
  logic                    is_mdu;
  logic                    mdu_start;
  logic [ex_pkg::xlen-1:0] sum;
  logic [ex_pkg::xlen-1:0] pc_link;
  logic                    lt_signed;
  logic                    lt_unsigned;
  logic [ex_pkg::xlen-1:0] alu_result;
  logic [ex_pkg::xlen-1:0] mdu_result;
  logic [ex_pkg::xlen-1:0] opnd_a;
  logic [ex_pkg::xlen-1:0] opnd_b;
  logic                    cnt_load;
  logic                    cnt_en;
  logic                    cnt_last;
  logic                    mdu_busy;
  logic                    mdu_done;
  ex_pkg::mdu_cmd_t        mdu_cmd;

  // one op in flight, so wait for the held result and the iterative unit
  assign in_ready  = !out_valid && !mdu_busy;
  assign accept    = in_valid && in_ready;
  assign is_mdu    = ex_pkg::is_mdu_op(in_req.op);
  assign mdu_start = accept && is_mdu;

  ex_adder u_adder (
    .a           (in_req.a),
    .b           (in_req.b),
    .pc          (in_req.pc),
    .op          (in_req.op),
    .sum         (sum),
    .pc_link     (pc_link),
    .lt_signed   (lt_signed),
    .lt_unsigned (lt_unsigned)
  );

  ex_alu u_alu (
    .op          (in_req.op),
    .a           (in_req.a),
    .b           (in_req.b),
    .sum         (sum),
    .pc_link     (pc_link),
    .lt_signed   (lt_signed),
    .lt_unsigned (lt_unsigned),
    .result      (alu_result)
  );

  // operands held here since the source may move on after the transfer
  always_ff @(posedge clk) begin
    if (mdu_start) begin
      opnd_a <= in_req.a;
      opnd_b <= in_req.b;
    end
  end

  // low two op bits are the mdu kind
  ex_mdu_ctrl u_mdu_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (mdu_start),
    .kind     (ex_pkg::mdu_kind_e'(in_req.op[1:0])),
    .last     (cnt_last),
    .cnt_load (cnt_load),
    .cnt_en   (cnt_en),
    .cmd      (mdu_cmd),
    .busy     (mdu_busy),
    .done     (mdu_done)
  );

  ex_iter_counter #(
    .steps (ex_pkg::iter_n)
  ) u_iter_counter (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (cnt_load),
    .en     (cnt_en),
    .last   (cnt_last)
  );

  ex_mdu_datapath u_mdu_datapath (
    .clk    (clk),
    .arst_n (arst_n),
    .cmd    (mdu_cmd),
    .a      (opnd_a),
    .b      (opnd_b),
    .result (mdu_result)
  );

  // output valid, set by a single-cycle accept or by done
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if ((accept && !is_mdu) || mdu_done) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (accept && !is_mdu) begin
      out_rsp.result <= alu_result;
    end else if (mdu_done) begin
      out_rsp.result <= mdu_result;
    end
  end

  // a stalled result must not move
  a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_rsp));

endmodule

// ==== sim/ex_stage_tb.sv ====
`timescale 1ns/1ps
module ex_stage_tb;

  localparam int xlen       = ex_pkg::xlen;
  localparam int rst_cycles = 5;
  localparam int n_random   = 40;
  // worst case per entry, iterative latency plus a stall margin
  localparam int per_entry  = ex_pkg::iter_n + 2 + 8;

  // one row of the stimulus table
  typedef struct packed {
    ex_pkg::alu_op_e op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] expected;
  } entry_t;

  logic            clk;
  logic            arst_n;
  logic            in_valid;
  logic            in_ready;
  ex_pkg::ex_req_t in_req;
  logic            out_valid;
  logic            out_ready;
  ex_pkg::ex_rsp_t out_rsp;

  entry_t          tbl[$];

  ex_stage dut0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

  // 4 ns period
  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  // expected result straight from the operation rules
  function automatic logic [xlen-1:0] reference_result(
    input ex_pkg::alu_op_e op,
    input logic [xlen-1:0] a,
    input logic [xlen-1:0] b,
    input logic [xlen-1:0] pc
  );
    logic [2*xlen-1:0] prod;
    logic [4:0]        sh;
    prod = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
    sh   = b[4:0];
    case (op)
      ex_pkg::ADD:   return a + b;
      ex_pkg::SUB,
      ex_pkg::SUBU:  return a - b;
      ex_pkg::SLL:   return a << sh;
      ex_pkg::SLT:   return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      ex_pkg::SLTU:  return {{(xlen-1){1'b0}}, a < b};
      ex_pkg::XOR:   return a ^ b;
      ex_pkg::SRL:   return a >> sh;
      ex_pkg::SRA:   return $signed(a) >>> sh;
      ex_pkg::OR:    return a | b;
      ex_pkg::AND:   return a & b;
      ex_pkg::PC:    return pc + 32'd4;
      ex_pkg::MUL:   return prod[xlen-1:0];
      ex_pkg::MULHU: return prod[2*xlen-1:xlen];
      // divide by zero gives all ones and the dividend
      ex_pkg::DIVU:  return (b == '0) ? '1 : a / b;
      ex_pkg::REMU:  return (b == '0) ? a : a % b;
      default:       return '0;
    endcase
  endfunction

  task automatic add_entry(
    input ex_pkg::alu_op_e op,
    input logic [xlen-1:0] a,
    input logic [xlen-1:0] b,
    input logic [xlen-1:0] pc,
    input logic [xlen-1:0] expected
  );
    tbl.push_back('{op, a, b, pc, expected});
  endtask

  task automatic add_random();
    ex_pkg::alu_op_e op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] pc;
    op = ex_pkg::alu_op_e'(4'($urandom_range(15)));
    a  = $urandom;
    // narrow divisors too, so quotients are not mostly zero
    b  = $urandom >> $urandom_range(31);
    pc = $urandom & 32'hFFFF_FFFC;
    add_entry(op, a, b, pc, reference_result(op, a, b, pc));
  endtask

  task automatic build_table();
    // add, subtract and link, with wraparound
    add_entry(ex_pkg::ADD,   32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'h0000_0000);
    add_entry(ex_pkg::ADD,   32'h1234_5678, 32'h1111_1111, 32'h0, 32'h2345_6789);
    add_entry(ex_pkg::SUB,   32'h0000_0000, 32'h0000_0001, 32'h0, 32'hFFFF_FFFF);
    add_entry(ex_pkg::SUBU,  32'h0000_0005, 32'h0000_0007, 32'h0, 32'hFFFF_FFFE);
    add_entry(ex_pkg::PC,    32'h0, 32'h0, 32'hFFFF_FFFC, 32'h0000_0000);
    add_entry(ex_pkg::PC,    32'h0, 32'h0, 32'h0000_1000, 32'h0000_1004);
    // compare edge cases
    add_entry(ex_pkg::SLT,   32'h8000_0000, 32'h7FFF_FFFF, 32'h0, 32'h0000_0001);
    add_entry(ex_pkg::SLT,   32'h7FFF_FFFF, 32'h8000_0000, 32'h0, 32'h0000_0000);
    add_entry(ex_pkg::SLTU,  32'h8000_0000, 32'h7FFF_FFFF, 32'h0, 32'h0000_0000);
    add_entry(ex_pkg::SLTU,  32'h7FFF_FFFF, 32'h8000_0000, 32'h0, 32'h0000_0001);
    add_entry(ex_pkg::SLT,   32'h0000_0005, 32'h0000_0005, 32'h0, 32'h0000_0000);
    // logic ops
    add_entry(ex_pkg::XOR,   32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0, 32'h0FF0_0FF0);
    add_entry(ex_pkg::OR,    32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0, 32'hFFF0_FFF0);
    add_entry(ex_pkg::AND,   32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0, 32'hF000_F000);
    // shifts, amounts 0 and 31, upper b bits ignored
    add_entry(ex_pkg::SLL,   32'h8000_0001, 32'h0000_0000, 32'h0, 32'h8000_0001);
    add_entry(ex_pkg::SLL,   32'h0000_0003, 32'h0000_001F, 32'h0, 32'h8000_0000);
    add_entry(ex_pkg::SRL,   32'h8000_0000, 32'h0000_001F, 32'h0, 32'h0000_0001);
    add_entry(ex_pkg::SRA,   32'h8000_0000, 32'h0000_001F, 32'h0, 32'hFFFF_FFFF);
    add_entry(ex_pkg::SRA,   32'h8000_0000, 32'h0000_0000, 32'h0, 32'h8000_0000);
    add_entry(ex_pkg::SRA,   32'h4000_0000, 32'h0000_0004, 32'h0, 32'h0400_0000);
    add_entry(ex_pkg::SRL,   32'hF000_0000, 32'h0000_0024, 32'h0, 32'h0F00_0000);
    // multiply high and low words
    add_entry(ex_pkg::MUL,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h0000_0001);
    add_entry(ex_pkg::MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'hFFFF_FFFE);
    add_entry(ex_pkg::MULHU, 32'h0001_0000, 32'h0001_0000, 32'h0, 32'h0000_0001);
    // divide, including by zero
    add_entry(ex_pkg::DIVU,  32'd100,       32'd7,         32'h0, 32'd14);
    add_entry(ex_pkg::REMU,  32'd100,       32'd7,         32'h0, 32'd2);
    add_entry(ex_pkg::DIVU,  32'h1234_5678, 32'h0000_0000, 32'h0, 32'hFFFF_FFFF);
    add_entry(ex_pkg::REMU,  32'h1234_5678, 32'h0000_0000, 32'h0, 32'h1234_5678);
    add_entry(ex_pkg::DIVU,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'hFFFF_FFFF);
    repeat (n_random) add_random();
  endtask

  initial begin
    int unsigned     limit;
    int unsigned     cycle;
    int              idx_in;
    int              idx_out;
    logic            in_fire_q;
    logic            out_fire_q;
    logic            out_valid_q;
    logic            out_ready_q;
    logic [xlen-1:0] rsp_q;
    entry_t          cur;

    void'($urandom(51897));
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_req    = '0;
    out_ready = 1'b0;
    build_table();
    limit = tbl.size() * per_entry + rst_cycles;

    repeat (rst_cycles) @(negedge clk);
    assert (!out_valid && in_ready)
      else abort_run("after reset out_valid is high or in_ready is low");
    arst_n = 1'b1;

    cycle       = 0;
    idx_in      = 0;
    idx_out     = 0;
    in_fire_q   = 1'b0;
    out_fire_q  = 1'b0;
    out_valid_q = 1'b0;
    out_ready_q = 1'b0;
    rsp_q       = '0;

    // all sampling and driving on the falling edge, registered outputs settled
    while (idx_out < tbl.size()) begin
      @(negedge clk);
      cycle++;
      assert (cycle <= limit)
        else abort_run("run timed out waiting for out_valid");

      // request accepted at the last rising edge
      if (in_fire_q) begin
        if (ex_pkg::is_mdu_op(tbl[idx_in].op)) begin
          assert (!out_valid)
            else abort_run("iterative result appeared one clock after acceptance");
        end else begin
          assert (out_valid)
            else abort_run("out_valid not set one clock after a single-cycle op");
        end
        idx_in++;
      end

      // result taken at the last rising edge, in table order
      if (out_fire_q) begin
        cur = tbl[idx_out];
        assert (rsp_q == cur.expected)
          else abort_run($sformatf("Mismatch at %0t: %s a=%h b=%h got %h expected %h",
                                   $time, cur.op.name(), cur.a, cur.b, rsp_q, cur.expected));
        assert (!out_valid)
          else abort_run("out_valid stayed high after the result was taken");
        idx_out++;
      end

      // stalled result holds
      if (out_valid_q && !out_ready_q) begin
        assert (out_valid && out_rsp.result == rsp_q)
          else abort_run($sformatf("Mismatch at %0t: stalled result moved from %h to %h",
                                   $time, rsp_q, out_rsp.result));
      end

      assert (!out_valid || idx_out < idx_in)
        else abort_run("out_valid raised with no request outstanding");
      // one op in flight
      assert (!in_ready || (!out_valid && idx_out == idx_in))
        else abort_run("in_ready high while a result is pending or the unit is busy");

      // next request, held until accepted, with random idle gaps
      if (in_fire_q || !in_valid) begin
        in_valid = (idx_in < tbl.size()) && ($urandom_range(3) != 0);
        if (in_valid) begin
          cur       = tbl[idx_in];
          in_req.op = cur.op;
          in_req.a  = cur.a;
          in_req.b  = cur.b;
          in_req.pc = cur.pc;
        end
      end
      // back-pressure about a third of the time
      out_ready = ($urandom_range(2) != 0);

      // what the coming rising edge will see
      in_fire_q   = in_valid && in_ready;
      out_fire_q  = out_valid && out_ready;
      out_valid_q = out_valid;
      out_ready_q = out_ready;
      rsp_q       = out_rsp.result;
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== all.f ====
source/ex_pkg.sv
source/ex_adder.sv
source/ex_alu.sv
source/ex_mdu_ctrl.sv
source/ex_iter_counter.sv
source/ex_mdu_datapath.sv
source/ex_stage.sv
sim/ex_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module ex_stage_tb -Mdir obj_dir -o ex_stage_sim

# the log decides the outcome
./obj_dir/ex_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
grep -q '\*\* PASS \*\*' sim.log
